// File: rtl/rv_pkg.sv
// Core widths, opcode and ALU encodings, control, data request and retire structs
package rv_pkg;

	localparam int xlen = 32;
	localparam logic [xlen-1:0] pc_reset = 32'h0000_0000;
	localparam int reg_count = 32;

	// RV32I major opcodes
	typedef enum logic [6:0] {
		op_load   = 7'b0000011,
		op_fence  = 7'b0001111,
		op_imm    = 7'b0010011,
		op_auipc  = 7'b0010111,
		op_store  = 7'b0100011,
		op_reg    = 7'b0110011,
		op_lui    = 7'b0110111,
		op_branch = 7'b1100011,
		op_jalr   = 7'b1100111,
		op_jal    = 7'b1101111
	} opcode_e;

	typedef enum logic [3:0] {
		alu_add    = 4'd0,
		alu_sub    = 4'd1,
		alu_sll    = 4'd2,
		alu_slt    = 4'd3,
		alu_sltu   = 4'd4,
		alu_xor    = 4'd5,
		alu_srl    = 4'd6,
		alu_sra    = 4'd7,
		alu_or     = 4'd8,
		alu_and    = 4'd9,
		alu_pass_b = 4'd10
	} alu_op_e;

	typedef enum logic [1:0] {
		wb_alu  = 2'd0,
		wb_load = 2'd1,
		wb_pc4  = 2'd2
	} wb_sel_e;

	typedef enum logic [1:0] {
		jump_seq    = 2'd0,
		jump_branch = 2'd1,
		jump_jal    = 2'd2,
		jump_jalr   = 2'd3
	} jump_e;

	// ALU operand A source
	typedef enum logic [1:0] {
		a_reg  = 2'd0,
		a_pc   = 2'd1,
		a_zero = 2'd2
	} a_sel_e;

	typedef struct packed {
		alu_op_e    alu_op;
		a_sel_e     a_sel;
		logic       b_imm;
		logic       reg_write;
		logic       mem_read;
		logic       mem_write;
		wb_sel_e    wb_sel;
		jump_e      jump;
		logic [2:0] funct3;
		logic       illegal;
	} ctrl_t;

	typedef struct packed {
		logic [xlen-1:0] addr;
		logic [xlen-1:0] wdata;
		logic [3:0]      strb;
		logic            re;
		logic            we;
	} dmem_req_t;

	typedef struct packed {
		logic [xlen-1:0] pc;
		logic [xlen-1:0] instr;
		logic [4:0]      rd;
		logic            we;
		logic [xlen-1:0] wdata;
	} retire_t;

endpackage

// File: rtl/control_decoder.sv
// Instruction decoder producing the full control word, ALU operation included
module control_decoder (
	input  logic [rv_pkg::xlen-1:0] i_instr,
	output rv_pkg::ctrl_t           o_ctrl
);

	logic [2:0] funct3;
	logic       alt;

	assign funct3 = i_instr[14:12];
	// funct7 bit 5 selects SUB and SRA
	assign alt = i_instr[30];

	function automatic rv_pkg::alu_op_e arith_op(input logic [2:0] f3, input logic f7_alt);
		rv_pkg::alu_op_e op;
		case (f3)
			3'b000:  op = f7_alt ? rv_pkg::alu_sub : rv_pkg::alu_add;
			3'b001:  op = rv_pkg::alu_sll;
			3'b010:  op = rv_pkg::alu_slt;
			3'b011:  op = rv_pkg::alu_sltu;
			3'b100:  op = rv_pkg::alu_xor;
			3'b101:  op = f7_alt ? rv_pkg::alu_sra : rv_pkg::alu_srl;
			3'b110:  op = rv_pkg::alu_or;
			default: op = rv_pkg::alu_and;
		endcase
		return op;
	endfunction

	always_comb begin
		o_ctrl.alu_op    = rv_pkg::alu_add;
		o_ctrl.a_sel     = rv_pkg::a_reg;
		o_ctrl.b_imm     = 1'b0;
		o_ctrl.reg_write = 1'b0;
		o_ctrl.mem_read  = 1'b0;
		o_ctrl.mem_write = 1'b0;
		o_ctrl.wb_sel    = rv_pkg::wb_alu;
		o_ctrl.jump      = rv_pkg::jump_seq;
		o_ctrl.funct3    = funct3;
		o_ctrl.illegal   = 1'b0;
		case (rv_pkg::opcode_e'(i_instr[6:0]))
			rv_pkg::op_reg: begin
				o_ctrl.alu_op    = arith_op(funct3, alt);
				o_ctrl.reg_write = 1'b1;
			end
			rv_pkg::op_imm: begin
				// Bit 30 is immediate data except for SRAI
				o_ctrl.alu_op    = arith_op(funct3, alt && funct3 == 3'b101);
				o_ctrl.b_imm     = 1'b1;
				o_ctrl.reg_write = 1'b1;
			end
			rv_pkg::op_lui: begin
				o_ctrl.alu_op    = rv_pkg::alu_pass_b;
				o_ctrl.a_sel     = rv_pkg::a_zero;
				o_ctrl.b_imm     = 1'b1;
				o_ctrl.reg_write = 1'b1;
			end
			rv_pkg::op_auipc: begin
				o_ctrl.a_sel     = rv_pkg::a_pc;
				o_ctrl.b_imm     = 1'b1;
				o_ctrl.reg_write = 1'b1;
			end
			rv_pkg::op_jal: begin
				o_ctrl.reg_write = 1'b1;
				o_ctrl.wb_sel    = rv_pkg::wb_pc4;
				o_ctrl.jump      = rv_pkg::jump_jal;
			end
			rv_pkg::op_jalr: begin
				o_ctrl.b_imm     = 1'b1;
				o_ctrl.reg_write = 1'b1;
				o_ctrl.wb_sel    = rv_pkg::wb_pc4;
				o_ctrl.jump      = rv_pkg::jump_jalr;
			end
			rv_pkg::op_branch: begin
				// Compare kind from funct3, sense inverted later by funct3[0]
				case (funct3[2:1])
					2'b00:   o_ctrl.alu_op = rv_pkg::alu_sub;
					2'b10:   o_ctrl.alu_op = rv_pkg::alu_slt;
					default: o_ctrl.alu_op = rv_pkg::alu_sltu;
				endcase
				o_ctrl.jump = rv_pkg::jump_branch;
			end
			rv_pkg::op_load: begin
				o_ctrl.b_imm     = 1'b1;
				o_ctrl.reg_write = 1'b1;
				o_ctrl.mem_read  = 1'b1;
				o_ctrl.wb_sel    = rv_pkg::wb_load;
			end
			rv_pkg::op_store: begin
				o_ctrl.b_imm     = 1'b1;
				o_ctrl.mem_write = 1'b1;
			end
			// FENCE has nothing to order in this core
			rv_pkg::op_fence: ;
			default: o_ctrl.illegal = 1'b1;
		endcase
	end

endmodule

// File: rtl/imm_gen.sv
// Immediate extraction and sign extension for the I, S, B, U and J formats
module imm_gen (
	input  logic [rv_pkg::xlen-1:0] i_instr,
	output logic [rv_pkg::xlen-1:0] o_imm
);

	always_comb begin
		case (rv_pkg::opcode_e'(i_instr[6:0]))
			rv_pkg::op_imm, rv_pkg::op_load, rv_pkg::op_jalr:
				o_imm = {{20{i_instr[31]}}, i_instr[31:20]};
			rv_pkg::op_store:
				o_imm = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
			// Branch and jump offsets already carry the zero LSB
			rv_pkg::op_branch:
				o_imm = {{19{i_instr[31]}}, i_instr[31], i_instr[7],
					i_instr[30:25], i_instr[11:8], 1'b0};
			rv_pkg::op_jal:
				o_imm = {{11{i_instr[31]}}, i_instr[31], i_instr[19:12],
					i_instr[20], i_instr[30:21], 1'b0};
			rv_pkg::op_lui, rv_pkg::op_auipc:
				o_imm = {i_instr[31:12], 12'b0};
			default:
				o_imm = '0;
		endcase
	end

endmodule

// File: rtl/register_file.sv
// Integer register file with x0 tied to zero, two read ports and one write port
module register_file (
	input  logic                    i_clk,
	input  logic [4:0]              i_rs1,
	input  logic [4:0]              i_rs2,
	input  logic [4:0]              i_rd,
	input  logic                    i_we,
	input  logic [rv_pkg::xlen-1:0] i_wdata,
	output logic [rv_pkg::xlen-1:0] o_rdata1,
	output logic [rv_pkg::xlen-1:0] o_rdata2
);

	// x0 has no storage
	logic [rv_pkg::xlen-1:0] regs [1:rv_pkg::reg_count-1];

	always_ff @(posedge i_clk) begin
		if (i_we && i_rd != 5'd0) begin
			regs[i_rd] <= i_wdata;
		end
	end

	assign o_rdata1 = (i_rs1 == 5'd0) ? '0 : regs[i_rs1];
	assign o_rdata2 = (i_rs2 == 5'd0) ? '0 : regs[i_rs2];

endmodule

// File: rtl/alu.sv
// ALU with arithmetic, logic and shift operations and the branch compare flag
module alu (
	input  rv_pkg::alu_op_e         i_op,
	input  logic [rv_pkg::xlen-1:0] i_a,
	input  logic [rv_pkg::xlen-1:0] i_b,
	output logic [rv_pkg::xlen-1:0] o_result,
	output logic                    o_cmp
);

	logic [4:0] shamt;
	logic       lt_signed;
	logic       lt_unsigned;

	assign shamt       = i_b[4:0];
	assign lt_signed   = $signed(i_a) < $signed(i_b);
	assign lt_unsigned = i_a < i_b;

	always_comb begin
		case (i_op)
			rv_pkg::alu_add:    o_result = i_a + i_b;
			rv_pkg::alu_sub:    o_result = i_a - i_b;
			rv_pkg::alu_sll:    o_result = i_a << shamt;
			rv_pkg::alu_slt:    o_result = {31'b0, lt_signed};
			rv_pkg::alu_sltu:   o_result = {31'b0, lt_unsigned};
			rv_pkg::alu_xor:    o_result = i_a ^ i_b;
			rv_pkg::alu_srl:    o_result = i_a >> shamt;
			rv_pkg::alu_sra:    o_result = $unsigned($signed(i_a) >>> shamt);
			rv_pkg::alu_or:     o_result = i_a | i_b;
			rv_pkg::alu_and:    o_result = i_a & i_b;
			rv_pkg::alu_pass_b: o_result = i_b;
			default:            o_result = '0;
		endcase
	end

	// The decoder picks SUB, SLT or SLTU to choose the branch compare
	always_comb begin
		case (i_op)
			rv_pkg::alu_slt:  o_cmp = lt_signed;
			rv_pkg::alu_sltu: o_cmp = lt_unsigned;
			default:          o_cmp = (i_a == i_b);
		endcase
	end

endmodule

// File: rtl/load_store_unit.sv
// Data-port request builder with byte strobes, and load alignment and extension
module load_store_unit (
	input  rv_pkg::ctrl_t           i_ctrl,
	input  logic                    i_active,
	input  logic [rv_pkg::xlen-1:0] i_addr,
	input  logic [rv_pkg::xlen-1:0] i_store_data,
	input  logic [rv_pkg::xlen-1:0] i_dmem_rdata,
	output rv_pkg::dmem_req_t       o_req,
	output logic [rv_pkg::xlen-1:0] o_load_data
);

	logic [1:0]              lane;
	logic [3:0]              strb;
	logic [rv_pkg::xlen-1:0] wdata;
	logic [7:0]              ld_byte;
	logic [15:0]             ld_half;

	assign lane = i_addr[1:0];

	// Replicate store data so the strobe alone picks the lane
	always_comb begin
		case (i_ctrl.funct3[1:0])
			2'b00: begin
				wdata = {4{i_store_data[7:0]}};
				strb  = 4'b0001 << lane;
			end
			2'b01: begin
				// Halfword truncated to its aligned pair
				wdata = {2{i_store_data[15:0]}};
				strb  = 4'b0011 << {lane[1], 1'b0};
			end
			default: begin
				wdata = i_store_data;
				strb  = 4'b1111;
			end
		endcase
	end

	assign o_req.addr  = {i_addr[rv_pkg::xlen-1:2], 2'b00};
	assign o_req.wdata = wdata;
	assign o_req.re    = i_active && i_ctrl.mem_read;
	assign o_req.we    = i_active && i_ctrl.mem_write;
	assign o_req.strb  = o_req.we ? strb : 4'b0000;

	assign ld_byte = i_dmem_rdata[8*lane +: 8];
	assign ld_half = i_dmem_rdata[16*lane[1] +: 16];

	// funct3[2] marks the unsigned variants
	always_comb begin
		case (i_ctrl.funct3[1:0])
			2'b00:   o_load_data = {{24{ld_byte[7] & ~i_ctrl.funct3[2]}}, ld_byte};
			2'b01:   o_load_data = {{16{ld_half[15] & ~i_ctrl.funct3[2]}}, ld_half};
			default: o_load_data = i_dmem_rdata;
		endcase
	end

endmodule

// File: rtl/core_sc.sv
// Single-cycle RV32I core top with PC, next-PC logic, datapath muxes and retire trace
module core_sc (
	input  logic                    i_clk,
	input  logic                    i_rst,
	input  logic [rv_pkg::xlen-1:0] i_imem_instr,
	input  logic                    i_imem_ready,
	input  logic                    i_dmem_ready,
	input  logic [rv_pkg::xlen-1:0] i_dmem_rdata,
	output logic [rv_pkg::xlen-1:0] o_imem_addr,
	output rv_pkg::dmem_req_t       o_dmem_req,
	output logic                    o_retire_valid,
	output rv_pkg::retire_t         o_retire
);

	logic [rv_pkg::xlen-1:0] pc;
	logic [rv_pkg::xlen-1:0] pc_next;
	logic [rv_pkg::xlen-1:0] pc_plus4;
	logic [rv_pkg::xlen-1:0] pc_target;
	logic                    run;
	logic                    fetch_ok;
	logic                    mem_access;
	logic                    retire;
	logic                    taken;

	rv_pkg::ctrl_t           ctrl;
	logic [rv_pkg::xlen-1:0] imm;
	logic [rv_pkg::xlen-1:0] rdata1;
	logic [rv_pkg::xlen-1:0] rdata2;
	logic [rv_pkg::xlen-1:0] op_a;
	logic [rv_pkg::xlen-1:0] op_b;
	logic [rv_pkg::xlen-1:0] alu_result;
	logic                    alu_cmp;
	logic [rv_pkg::xlen-1:0] load_data;
	logic [rv_pkg::xlen-1:0] wb_data;
	logic [4:0]              rd;

	// Held low through reset and the first cycle after it
	always_ff @(posedge i_clk) begin
		if (!i_rst) begin
			run <= 1'b0;
		end else begin
			run <= 1'b1;
		end
	end

	always_ff @(posedge i_clk) begin
		if (!i_rst) begin
			pc <= rv_pkg::pc_reset;
		end else if (retire) begin
			pc <= pc_next;
		end
	end

	assign o_imem_addr = pc;
	assign rd          = i_imem_instr[11:7];

	// One condition moves PC, register file and trace together
	assign fetch_ok   = run && i_imem_ready;
	assign mem_access = ctrl.mem_read || ctrl.mem_write;
	assign retire     = fetch_ok && (!mem_access || i_dmem_ready);

	control_decoder u_decoder (
		.i_instr (i_imem_instr),
		.o_ctrl  (ctrl)
	);

	imm_gen u_imm_gen (
		.i_instr (i_imem_instr),
		.o_imm   (imm)
	);

	register_file u_regs (
		.i_clk    (i_clk),
		.i_rs1    (i_imem_instr[19:15]),
		.i_rs2    (i_imem_instr[24:20]),
		.i_rd     (rd),
		.i_we     (retire && ctrl.reg_write),
		.i_wdata  (wb_data),
		.o_rdata1 (rdata1),
		.o_rdata2 (rdata2)
	);

	always_comb begin
		case (ctrl.a_sel)
			rv_pkg::a_pc:   op_a = pc;
			rv_pkg::a_zero: op_a = '0;
			default:        op_a = rdata1;
		endcase
	end

	assign op_b = ctrl.b_imm ? imm : rdata2;

	alu u_alu (
		.i_op     (ctrl.alu_op),
		.i_a      (op_a),
		.i_b      (op_b),
		.o_result (alu_result),
		.o_cmp    (alu_cmp)
	);

	load_store_unit u_lsu (
		.i_ctrl       (ctrl),
		.i_active     (fetch_ok),
		.i_addr       (alu_result),
		.i_store_data (rdata2),
		.i_dmem_rdata (i_dmem_rdata),
		.o_req        (o_dmem_req),
		.o_load_data  (load_data)
	);

	// funct3[0] inverts the compare for BNE, BGE and BGEU
	assign taken     = alu_cmp ^ ctrl.funct3[0];
	assign pc_plus4  = pc + 32'd4;
	assign pc_target = pc + imm;

	always_comb begin
		case (ctrl.jump)
			rv_pkg::jump_branch: pc_next = taken ? pc_target : pc_plus4;
			rv_pkg::jump_jal:    pc_next = pc_target;
			rv_pkg::jump_jalr:   pc_next = {alu_result[rv_pkg::xlen-1:1], 1'b0};
			default:             pc_next = pc_plus4;
		endcase
	end

	always_comb begin
		case (ctrl.wb_sel)
			rv_pkg::wb_load: wb_data = load_data;
			rv_pkg::wb_pc4:  wb_data = pc_plus4;
			default:         wb_data = alu_result;
		endcase
	end

	assign o_retire_valid = retire;
	assign o_retire.pc    = pc;
	assign o_retire.instr = i_imem_instr;
	assign o_retire.rd    = rd;
	assign o_retire.we    = ctrl.reg_write;
	// Value as the register file sees it, so x0 reads back zero
	assign o_retire.wdata = (ctrl.reg_write && rd != 5'd0) ? wb_data : '0;

endmodule

// File: testbench/core_properties.sv
// Concurrent assertions on stall, hold and reset behavior of the core top
module core_properties (
	input logic              i_clk,
	input logic              i_rst,
	input logic              i_imem_ready,
	input logic              i_dmem_ready,
	input logic [31:0]       i_imem_addr,
	input rv_pkg::dmem_req_t i_dmem_req,
	input logic              i_retire_valid
);
	timeunit 1ns;
	timeprecision 100ps;

	logic mem_busy;

	assign mem_busy = i_dmem_req.re || i_dmem_req.we;

	// No retirement while the core is held in reset
	reset_quiet: assert property (@(posedge i_clk) !i_rst |-> !i_retire_valid)
		else $error("retire valid asserted during reset");

	fetch_stall: assert property (@(posedge i_clk) disable iff (!i_rst)
		!i_imem_ready |-> !i_retire_valid)
		else $error("retired while instruction port not ready");

	data_stall: assert property (@(posedge i_clk) disable iff (!i_rst)
		(mem_busy && !i_dmem_ready) |-> !i_retire_valid)
		else $error("retired while data port not ready");

	// PC only moves on retirement
	pc_hold: assert property (@(posedge i_clk) disable iff (!i_rst)
		!i_retire_valid |=> $stable(i_imem_addr))
		else $error("fetch address moved without retirement");

	req_hold: assert property (@(posedge i_clk) disable iff (!i_rst)
		(mem_busy && !i_dmem_ready) |=> $stable(i_dmem_req))
		else $error("data request changed during stall");

endmodule

// File: testbench/tb_core.sv
// Testbench for the single-cycle core with stalling memories, program generator and ISA model
module tb_core;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int retire_target = 400;
	localparam int wait_limit    = 2000;

	logic                    i_clk;
	logic                    i_rst;
	logic [31:0]             i_imem_instr;
	logic                    i_imem_ready;
	logic                    i_dmem_ready;
	logic [31:0]             i_dmem_rdata;
	logic [31:0]             o_imem_addr;
	rv_pkg::dmem_req_t       o_dmem_req;
	logic                    o_retire_valid;
	rv_pkg::retire_t         o_retire;

	logic [31:0] imem [0:255];
	logic [31:0] dmem [0:63];
	logic [31:0] mdmem [0:63];
	logic [31:0] mregs [0:31];
	logic [31:0] mpc;

	// Memory response state
	logic              ipending;
	logic              dpending;
	int                iwait;
	int                dwait;
	logic [5:0]        daddr;
	rv_pkg::dmem_req_t dreq;
	logic              held_valid;
	logic [31:0]       held_addr;
	int                retired;

	core_sc i_dut (
		.i_clk          (i_clk),
		.i_rst          (i_rst),
		.i_imem_instr   (i_imem_instr),
		.i_imem_ready   (i_imem_ready),
		.i_dmem_ready   (i_dmem_ready),
		.i_dmem_rdata   (i_dmem_rdata),
		.o_imem_addr    (o_imem_addr),
		.o_dmem_req     (o_dmem_req),
		.o_retire_valid (o_retire_valid),
		.o_retire       (o_retire)
	);

	bind core_sc core_properties u_props (
		.i_clk          (i_clk),
		.i_rst          (i_rst),
		.i_imem_ready   (i_imem_ready),
		.i_dmem_ready   (i_dmem_ready),
		.i_imem_addr    (o_imem_addr),
		.i_dmem_req     (o_dmem_req),
		.i_retire_valid (o_retire_valid)
	);

	initial begin
		i_clk = 1'b0;
		forever #2 i_clk = ~i_clk;
	end

	task automatic abort_run(input string msg);
		$display("Failure at %0t ns: %s", $time, msg);
		$display("Simulation FAILED");
		$fatal(1, "run aborted");
	endtask

	task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
			$display("Simulation FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	// Instruction encoders
	function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
			input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
	endfunction

	function automatic logic [31:0] random_instr(input int idx);
		int         kind;
		int         t;
		int         k;
		logic [2:0] f3;
		logic [4:0] rd;
		logic [4:0] rs1;
		logic [4:0] rs2;
		logic [1:0] lane;
		logic [11:0] off;
		logic [6:0] f7;
		kind = $urandom % 16;
		rd   = 5'($urandom % 16);
		rs1  = 5'($urandom % 16);
		rs2  = 5'($urandom % 16);
		f3   = 3'($urandom % 8);
		k    = 1 + $urandom % 4;
		if (idx + k > 255) begin
			k = 255 - idx;
		end
		f7 = ((f3 == 3'd0 || f3 == 3'd5) && $urandom % 2 == 1) ? 7'h20 : 7'h00;
		if (kind < 4) begin
			return {f7, rs2, rs1, f3, rd, 7'b0110011};
		end else if (kind < 7) begin
			if (f3 == 3'd1 || f3 == 3'd5) begin
				return enc_i({f3 == 3'd5 ? f7 : 7'h00, 5'($urandom)}, rs1, f3, rd, 7'b0010011);
			end
			return enc_i(12'($urandom), rs1, f3, rd, 7'b0010011);
		end else if (kind < 9) begin
			return {20'($urandom), rd, kind == 7 ? 7'b0110111 : 7'b0010111};
		end else if (kind < 13) begin
			t = $urandom % 5;
			if (kind < 11) begin
				f3 = 3'(t < 3 ? t : t + 1);
			end else begin
				f3 = 3'($urandom % 3);
			end
			case (f3[1:0])
				2'b00:   lane = 2'($urandom % 4);
				2'b01:   lane = 2'(2 * ($urandom % 2));
				default: lane = 2'b00;
			endcase
			off = {4'b0, 6'($urandom % 64), lane};
			if (kind < 11) begin
				return enc_i(off, 5'd0, f3, rd, 7'b0000011);
			end
			return enc_s(off, rs2, 5'd0, f3);
		end else if (kind == 13) begin
			t  = $urandom % 6;
			f3 = 3'(t < 2 ? t : t + 2);
			return enc_b(13'(4 * k), rs2, rs1, f3);
		end else if (kind == 14) begin
			return enc_j(21'(4 * k), rd);
		end
		// JALR off x0 to an absolute forward target
		return enc_i(12'(4 * (idx + k)), 5'd0, 3'b000, rd, 7'b1100111);
	endfunction

	function automatic logic [31:0] model_alu(input logic [2:0] f3, input logic alt,
			input logic [31:0] a, input logic [31:0] b);
		logic [31:0] r;
		case (f3)
			3'd0: r = alt ? a - b : a + b;
			3'd1: r = a << b[4:0];
			3'd2: r = {31'b0, $signed(a) < $signed(b)};
			3'd3: r = {31'b0, a < b};
			3'd4: r = a ^ b;
			3'd5: begin
				// Arithmetic shift fills the vacated bits with the sign
				r = a >> b[4:0];
				if (alt) begin
					r = r | ({32{a[31]}} & ~(32'hffff_ffff >> b[4:0]));
				end
			end
			3'd6: r = a | b;
			default: r = a & b;
		endcase
		return r;
	endfunction

	// One instruction of the reference ISA model
	task automatic model_step(input logic [31:0] in, output logic [4:0] e_rd,
			output logic e_we, output logic [31:0] e_val, output logic [3:0] e_strb);
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm_i;
		logic [31:0] imm_s;
		logic [31:0] imm_b;
		logic [31:0] imm_j;
		logic [31:0] addr;
		logic [31:0] word;
		logic [31:0] shifted;
		logic [31:0] npc;
		logic [2:0]  f3;
		logic        take;
		a      = mregs[in[19:15]];
		b      = mregs[in[24:20]];
		f3     = in[14:12];
		imm_i  = {{20{in[31]}}, in[31:20]};
		imm_s  = {{20{in[31]}}, in[31:25], in[11:7]};
		imm_b  = {{19{in[31]}}, in[31], in[7], in[30:25], in[11:8], 1'b0};
		imm_j  = {{11{in[31]}}, in[31], in[19:12], in[20], in[30:21], 1'b0};
		e_rd   = in[11:7];
		e_we   = 1'b1;
		e_val  = 32'd0;
		e_strb = 4'b0000;
		npc    = mpc + 32'd4;
		case (in[6:0])
			7'b0110011: e_val = model_alu(f3, in[30], a, b);
			7'b0010011: e_val = model_alu(f3, in[30] && f3 == 3'd5, a, imm_i);
			7'b0110111: e_val = {in[31:12], 12'b0};
			7'b0010111: e_val = mpc + {in[31:12], 12'b0};
			7'b1101111: begin
				e_val = mpc + 32'd4;
				npc   = mpc + imm_j;
			end
			7'b1100111: begin
				e_val = mpc + 32'd4;
				npc   = (a + imm_i) & ~32'd1;
			end
			7'b1100011: begin
				e_we = 1'b0;
				case (f3)
					3'd0: take = a == b;
					3'd1: take = a != b;
					3'd4: take = $signed(a) < $signed(b);
					3'd5: take = $signed(a) >= $signed(b);
					3'd6: take = a < b;
					default: take = a >= b;
				endcase
				if (take) begin
					npc = mpc + imm_b;
				end
			end
			7'b0000011: begin
				addr = a + imm_i;
				word = mdmem[addr[7:2]];
				case (f3)
					3'd0: e_val = {{24{word[8*addr[1:0]+7]}}, word[8*addr[1:0] +: 8]};
					3'd4: e_val = {24'b0, word[8*addr[1:0] +: 8]};
					3'd1: e_val = {{16{word[16*addr[1]+15]}}, word[16*addr[1] +: 16]};
					3'd5: e_val = {16'b0, word[16*addr[1] +: 16]};
					default: e_val = word;
				endcase
			end
			7'b0100011: begin
				e_we    = 1'b0;
				addr    = a + imm_s;
				shifted = b << (8 * addr[1:0]);
				case (f3[1:0])
					2'b00:   e_strb = 4'b0001 << addr[1:0];
					2'b01:   e_strb = 4'b0011 << addr[1:0];
					default: e_strb = 4'b1111;
				endcase
				for (int j = 0; j < 4; j++) begin
					if (e_strb[j]) begin
						mdmem[addr[7:2]][8*j +: 8] = shifted[8*j +: 8];
					end
				end
			end
			// FENCE and unknown opcodes
			default: e_we = 1'b0;
		endcase
		if (e_we && e_rd != 5'd0) begin
			mregs[e_rd] = e_val;
		end else begin
			e_val = 32'd0;
		end
		mpc = npc;
	endtask

	task automatic apply_store(input rv_pkg::dmem_req_t req);
		for (int j = 0; j < 4; j++) begin
			if (req.strb[j]) begin
				dmem[req.addr[7:2]][8*j +: 8] = req.wdata[8*j +: 8];
			end
		end
	endtask

	// Memories answer on the falling edge with random wait states
	always @(negedge i_clk) begin
		if (!ipending) begin
			ipending     = 1'b1;
			iwait        = $urandom % 4;
			i_imem_instr = imem[o_imem_addr[9:2]];
		end
		if (iwait > 0) begin
			i_imem_ready = 1'b0;
			iwait--;
		end else begin
			i_imem_ready = 1'b1;
		end
		if (dpending && dwait > 0) begin
			i_dmem_ready = 1'b0;
			dwait--;
		end else if (dpending) begin
			i_dmem_ready = 1'b1;
			i_dmem_rdata = dmem[daddr];
		end else begin
			i_dmem_ready = 1'b0;
		end
	end

	always @(posedge i_clk) begin
		logic [4:0]  e_rd;
		logic        e_we;
		logic [31:0] e_val;
		logic [3:0]  e_strb;
		logic [5:0]  sidx;
		// An accepted data request stays put until it retires
		if (i_rst && dpending) begin
			check_value("held data address", o_dmem_req.addr, dreq.addr);
			check_value("held store data", o_dmem_req.wdata, dreq.wdata);
			check_value("held data controls",
				32'({o_dmem_req.strb, o_dmem_req.re, o_dmem_req.we}),
				32'({dreq.strb, dreq.re, dreq.we}));
		end
		if (i_rst && o_retire_valid) begin
			if (!i_imem_ready) begin
				abort_run("retired while instruction port not ready");
			end
			if ((o_dmem_req.re || o_dmem_req.we) && !i_dmem_ready) begin
				abort_run("retired while data port not ready");
			end
			sidx = o_dmem_req.addr[7:2];
			if (o_dmem_req.we) begin
				apply_store(o_dmem_req);
			end
			check_value("retire pc", o_retire.pc, mpc);
			check_value("retire instr", o_retire.instr, imem[mpc[9:2]]);
			model_step(o_retire.instr, e_rd, e_we, e_val, e_strb);
			check_value("retire rd", 32'(o_retire.rd), 32'(e_rd));
			check_value("retire we", 32'(o_retire.we), 32'(e_we));
			check_value("retire value", o_retire.wdata, e_val);
			check_value("store strobe", 32'(o_dmem_req.strb), 32'(e_strb));
			if (o_dmem_req.we) begin
				check_value("stored word", dmem[sidx], mdmem[sidx]);
			end
			retired++;
			ipending   = 1'b0;
			dpending   = 1'b0;
			held_valid = 1'b0;
		end else if (i_rst) begin
			if (held_valid) begin
				check_value("stalled fetch address", o_imem_addr, held_addr);
			end
			held_valid = 1'b1;
			held_addr  = o_imem_addr;
			if (!dpending && (o_dmem_req.re || o_dmem_req.we)) begin
				dpending = 1'b1;
				dwait    = $urandom % 4;
				daddr    = o_dmem_req.addr[7:2];
				dreq     = o_dmem_req;
			end
		end
	end

	initial begin
		int start;
		int cycles;
		i_rst        = 1'b0;
		i_imem_instr = 32'h0000_0013;
		i_imem_ready = 1'b0;
		i_dmem_ready = 1'b0;
		i_dmem_rdata = 32'd0;
		ipending     = 1'b0;
		dpending     = 1'b0;
		iwait        = 0;
		dwait        = 0;
		daddr        = 6'd0;
		dreq         = '0;
		held_valid   = 1'b0;
		held_addr    = 32'd0;
		retired      = 0;
		void'($urandom(94803));
		for (int i = 0; i < 64; i++) begin
			dmem[i]  = $urandom ^ (32'(i) * 32'h0101_0101);
			mdmem[i] = dmem[i];
		end
		for (int i = 0; i < 32; i++) begin
			mregs[i] = 32'd0;
		end
		mpc = rv_pkg::pc_reset;
		// Give x1 to x15 known values before the random part
		for (int i = 0; i < 15; i++) begin
			imem[i] = enc_i(12'($urandom), 5'd0, 3'b000, 5'(i + 1), 7'b0010011);
		end
		for (int i = 15; i < 255; i++) begin
			imem[i] = random_instr(i);
		end
		// Program ends in a jump to itself
		imem[255] = enc_j(21'd0, 5'd0);
		repeat (16) @(negedge i_clk);
		i_rst = 1'b1;
		@(negedge i_clk);
		check_value("fetch address after reset", o_imem_addr, rv_pkg::pc_reset);
		while (retired < retire_target) begin
			start  = retired;
			cycles = 0;
			while (retired == start) begin
				@(negedge i_clk);
				cycles++;
				if (cycles > wait_limit) begin
					abort_run("timeout waiting for a retirement");
				end
			end
		end
		$display("Simulation PASSED");
		$finish;
	end

endmodule

// File: files.f
rtl/rv_pkg.sv
rtl/control_decoder.sv
rtl/imm_gen.sv
rtl/register_file.sv
rtl/alu.sv
rtl/load_store_unit.sv
rtl/core_sc.sv
testbench/core_properties.sv
testbench/tb_core.sv

// File: Makefile
# Verilator build and run for the single-cycle core

VERILATOR  ?= verilator
TOP        := tb_core
FILELIST   := files.f
OBJ_DIR    := obj_dir
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
